/* src.f */
verilog/wb_adder_pkg.sv
verilog/wb_stream_bridge.sv
verilog/stream_adder.sv
verilog/wb_adder_top.sv
bench/wb_adder_tb.sv

/* Bender.yml */
package:
  name: wb_adder

sources:
  # synthesizable design
  - target: any(rtl, simulation)
    files:
      - verilog/wb_adder_pkg.sv
      - verilog/wb_stream_bridge.sv
      - verilog/stream_adder.sv
      - verilog/wb_adder_top.sv

  # testbench
  - target: simulation
    files:
      - bench/wb_adder_tb.sv

/* bench/wb_adder_tb.sv */
`default_nettype none

module wb_adder_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                clk;
  logic                i_rst_n;
  logic                i_wb_cyc;
  logic                i_wb_stb;
  logic                i_wb_we;
  wb_adder_pkg::sel_t  i_wb_sel;
  wb_adder_pkg::addr_t i_wb_adr;
  wb_adder_pkg::word_t i_wb_dat;
  logic                o_wb_ack;
  wb_adder_pkg::word_t o_wb_dat;

  // expected read data for the access in flight
  wb_adder_pkg::word_t exp_dat;
  // high while a write must stay unacked
  logic                stall_chk;
  int                  errors;
  int                  accesses;
  wb_adder_pkg::word_t lfsr_q;

  // reference model of the adder
  logic                m_half;
  logic                m_held;
  wb_adder_pkg::word_t m_a;
  wb_adder_pkg::word_t m_sum;

  wb_adder_top dut (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_sel (i_wb_sel),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_ack (o_wb_ack),
    .o_wb_dat (o_wb_dat)
  );

  always #2 clk = ~clk;

  // every ack carries the data the model predicts
  a_rdata: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wb_ack |-> (o_wb_dat == exp_dat))
  else
  begin
    errors++;
    $display("error at %0t: o_wb_dat expected %h got %h", $time, $sampled(exp_dat),
             $sampled(o_wb_dat));
  end

  a_ack_reset: assert property (@(posedge clk) !i_rst_n |=> !o_wb_ack)
  else
  begin
    errors++;
    $display("error at %0t: o_wb_ack expected 0 got 1 after reset", $time);
  end

  // operand write while a sum is held must not complete
  a_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    stall_chk |-> !o_wb_ack)
  else
  begin
    errors++;
    $display("error at %0t: o_wb_ack expected 0 got 1 while a sum is held", $time);
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic wb_adder_pkg::word_t lfsr_step(input wb_adder_pkg::word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic wb_adder_pkg::word_t lane_mask(input wb_adder_pkg::word_t d,
                                                    input wb_adder_pkg::sel_t s);
    return d & {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  function automatic wb_adder_pkg::word_t status_model();
    wb_adder_pkg::word_t s;
    s = '0;
    s[wb_adder_pkg::STAT_IN_RDY]  = !m_held;
    s[wb_adder_pkg::STAT_OUT_VAL] = m_held;
    s[wb_adder_pkg::STAT_HALF]    = m_half;
    return s;
  endfunction

  task automatic rand_word(output wb_adder_pkg::word_t w);
    for (int i = 0; i < 32; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      w[i] = lfsr_q[0];
    end
  endtask

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic drop_request();
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_sel = '0;
    i_wb_adr = '0;
    i_wb_dat = '0;
  endtask

  task automatic apply_reset();
    i_rst_n = 1'b0;
    repeat (4) next_cycle();
    i_rst_n = 1'b1;
    m_half = 1'b0;
    m_held = 1'b0;
  endtask

  task automatic bus_access(input logic we, input wb_adder_pkg::addr_t adr,
                            input wb_adder_pkg::sel_t sel, input wb_adder_pkg::word_t wdat,
                            input wb_adder_pkg::word_t exp_rdata);
    int n;
    exp_dat  = exp_rdata;
    accesses++;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_sel = sel;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    n = 0;
    while (!o_wb_ack && n < 50)
    begin
      next_cycle();
      n++;
    end
    if (!o_wb_ack)
    begin
      errors++;
      $display("%s of address %h got no ack within 50 cycles", we ? "write" : "read", adr);
    end
    else
      next_cycle();
    drop_request();
  endtask

  task automatic bus_write(input wb_adder_pkg::addr_t adr, input wb_adder_pkg::sel_t sel,
                           input wb_adder_pkg::word_t d);
    bus_access(1'b1, adr, sel, d, '0);
  endtask

  task automatic bus_read(input wb_adder_pkg::addr_t adr, input wb_adder_pkg::word_t exp);
    bus_access(1'b0, adr, 4'hf, '0, exp);
  endtask

  task automatic push_operand(input wb_adder_pkg::word_t d, input wb_adder_pkg::sel_t s);
    wb_adder_pkg::word_t v;
    v = lane_mask(d, s);
    bus_write(wb_adder_pkg::ADDR_OPERAND, s, d);
    if (!m_half)
    begin
      m_a    = v;
      m_half = 1'b1;
    end
    else
    begin
      m_sum  = m_a + v;
      m_half = 1'b0;
      m_held = 1'b1;
    end
  endtask

  task automatic pop_result();
    bus_read(wb_adder_pkg::ADDR_RESULT, m_sum);
    m_held = 1'b0;
  endtask

  task automatic check_status();
    bus_read(wb_adder_pkg::ADDR_STATUS, status_model());
  endtask

  task automatic add_pair(input wb_adder_pkg::word_t a, input wb_adder_pkg::word_t b);
    push_operand(a, 4'hf);
    push_operand(b, 4'hf);
    pop_result();
  endtask

  // the bridge waits in push until the adder takes the operand, and the
  // sum cannot be popped over the same port meanwhile, so reset clears it
  task automatic stall_write(input wb_adder_pkg::word_t d);
    i_wb_cyc  = 1'b1;
    i_wb_stb  = 1'b1;
    i_wb_we   = 1'b1;
    i_wb_sel  = 4'hf;
    i_wb_adr  = wb_adder_pkg::ADDR_OPERAND;
    i_wb_dat  = d;
    stall_chk = 1'b1;
    for (int n = 0; n < 20; n++)
      next_cycle();
    stall_chk = 1'b0;
    drop_request();
    apply_reset();
  endtask

  initial
  begin
    wb_adder_pkg::word_t a;
    wb_adder_pkg::word_t b;
    clk       = 1'b0;
    i_rst_n   = 1'b0;
    exp_dat   = '0;
    stall_chk = 1'b0;
    errors    = 0;
    accesses  = 0;
    lfsr_q    = 32'h57c8eb78;
    drop_request();
    apply_reset();

    check_status();

    // random and overflowing pairs
    for (int i = 0; i < 8; i++)
    begin
      rand_word(a);
      rand_word(b);
      add_pair(a, b);
    end
    add_pair(32'hffff_ffff, 32'h0000_0001);
    add_pair(32'h8000_0000, 32'h8000_0000);
    add_pair(32'hffff_ffff, 32'hffff_ffff);

    // partial byte selects
    rand_word(a);
    rand_word(b);
    push_operand(a, 4'b0101);
    push_operand(b, 4'b1000);
    pop_result();
    push_operand(a, 4'b0000);
    push_operand(b, 4'b0110);
    pop_result();

    // status walk through one pair
    check_status();
    push_operand(32'h1234_5678, 4'hf);
    check_status();
    push_operand(32'h0101_0101, 4'hf);
    check_status();
    pop_result();
    check_status();

    // third operand stalls while the sum waits
    add_pair(32'h0000_0010, 32'h0000_0020);
    push_operand(32'h0000_0003, 4'hf);
    push_operand(32'h0000_0004, 4'hf);
    stall_write(32'h0000_0005);
    check_status();

    // accesses that must not touch the adder
    push_operand(32'h0000_1000, 4'hf);
    bus_read(32'h3000_0010, '0);
    bus_write(32'h3000_0010, 4'hf, 32'hdead_beef);
    bus_write(wb_adder_pkg::ADDR_RESULT, 4'hf, 32'hdead_beef);
    bus_write(wb_adder_pkg::ADDR_STATUS, 4'hf, 32'hdead_beef);
    bus_read(wb_adder_pkg::ADDR_OPERAND, '0);
    check_status();
    push_operand(32'h0000_0234, 4'hf);
    check_status();
    pop_result();
    check_status();

    next_cycle();
    $display("accesses %0d errors %0d", accesses, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/wb_adder_top.sv */
`default_nettype none

module wb_adder_top (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_wb_cyc,
  input  logic                i_wb_stb,
  input  logic                i_wb_we,
  input  wb_adder_pkg::sel_t  i_wb_sel,
  input  wb_adder_pkg::addr_t i_wb_adr,
  input  wb_adder_pkg::word_t i_wb_dat,
  output logic                o_wb_ack,
  output wb_adder_pkg::word_t o_wb_dat
);

  // bridge to adder
  logic                op_val;
  wb_adder_pkg::word_t op_data;
  logic                op_rdy;

  // adder to bridge
  logic                sum_val;
  wb_adder_pkg::word_t sum_data;
  logic                sum_rdy;
  logic                half;

  wb_stream_bridge bridge (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_sel   (i_wb_sel),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .o_op_val   (op_val),
    .o_op_data  (op_data),
    .i_op_rdy   (op_rdy),
    .i_sum_val  (sum_val),
    .i_sum_data (sum_data),
    .o_sum_rdy  (sum_rdy),
    .i_half     (half),
    .o_wb_ack   (o_wb_ack),
    .o_wb_dat   (o_wb_dat)
  );

  stream_adder adder (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_op_val   (op_val),
    .i_op_data  (op_data),
    .o_op_rdy   (op_rdy),
    .o_sum_val  (sum_val),
    .o_sum_data (sum_data),
    .i_sum_rdy  (sum_rdy),
    .o_half     (half)
  );

endmodule

`default_nettype wire

/* verilog/stream_adder.sv */
`default_nettype none

module stream_adder (
  input  logic                clk,
  input  logic                i_rst_n,
  // operand stream in
  input  logic                i_op_val,
  input  wb_adder_pkg::word_t i_op_data,
  output logic                o_op_rdy,
  // sum stream out
  output logic                o_sum_val,
  output wb_adder_pkg::word_t o_sum_data,
  input  logic                i_sum_rdy,
  // first operand held
  output logic                o_half
);

  typedef enum logic [1:0] {
    S_EMPTY,
    S_HAVE_A,
    S_HAVE_SUM
  } state_e;

  state_e              state_q;
  wb_adder_pkg::word_t a_q;
  wb_adder_pkg::word_t sum_q;
  logic                op_xfer;
  logic                sum_xfer;

  assign op_xfer  = i_op_val && o_op_rdy;
  assign sum_xfer = o_sum_val && i_sum_rdy;

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      state_q <= S_EMPTY;
    end
    else
    begin
      case (state_q)
        S_EMPTY:
        begin
          if (op_xfer)
            state_q <= S_HAVE_A;
        end
        S_HAVE_A:
        begin
          if (op_xfer)
            state_q <= S_HAVE_SUM;
        end
        S_HAVE_SUM:
        begin
          if (sum_xfer)
            state_q <= S_EMPTY;
        end
        default:
        begin
          state_q <= S_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (op_xfer && state_q == S_EMPTY)
    begin
      a_q <= i_op_data;
    end
    // carry out dropped so the sum wraps at 2^32
    if (op_xfer && state_q == S_HAVE_A)
    begin
      sum_q <= a_q + i_op_data;
    end
  end

  // no new operands while a sum waits
  assign o_op_rdy   = (state_q != S_HAVE_SUM);
  assign o_sum_val  = (state_q == S_HAVE_SUM);
  assign o_sum_data = sum_q;
  assign o_half     = (state_q == S_HAVE_A);

  a_rdy_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(o_op_rdy && o_sum_val));

  // sum stays put until popped
  a_sum_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_sum_val && !i_sum_rdy) |=> (o_sum_val && $stable(o_sum_data)));

endmodule

`default_nettype wire

/* verilog/wb_stream_bridge.sv */
`default_nettype none

module wb_stream_bridge (
  input  logic                clk,
  input  logic                i_rst_n,
  // wishbone classic slave
  input  logic                i_wb_cyc,
  input  logic                i_wb_stb,
  input  logic                i_wb_we,
  input  wb_adder_pkg::sel_t  i_wb_sel,
  input  wb_adder_pkg::addr_t i_wb_adr,
  input  wb_adder_pkg::word_t i_wb_dat,
  // operand stream to the adder
  output logic                o_op_val,
  output wb_adder_pkg::word_t o_op_data,
  input  logic                i_op_rdy,
  // sum stream from the adder
  input  logic                i_sum_val,
  input  wb_adder_pkg::word_t i_sum_data,
  output logic                o_sum_rdy,
  // adder holds a first operand
  input  logic                i_half,
  // bus response
  output logic                o_wb_ack,
  output wb_adder_pkg::word_t o_wb_dat
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_PUSH,
    S_POP,
    S_ACK
  } state_e;

  state_e              state_q;
  wb_adder_pkg::word_t op_data_q;
  wb_adder_pkg::word_t rdata_q;
  wb_adder_pkg::word_t masked_dat;
  wb_adder_pkg::word_t status_word;
  logic                req;
  logic                hit_operand;
  logic                hit_result;
  logic                hit_status;

  // new access only sampled while idle
  assign req = i_wb_cyc && i_wb_stb && (state_q == S_IDLE);

  // full address decode
  assign hit_operand = (i_wb_adr == wb_adder_pkg::ADDR_OPERAND);
  assign hit_result  = (i_wb_adr == wb_adder_pkg::ADDR_RESULT);
  assign hit_status  = (i_wb_adr == wb_adder_pkg::ADDR_STATUS);

  // unselected byte lanes read as zero
  always_comb
  begin
    for (int i = 0; i < $bits(wb_adder_pkg::sel_t); i++)
    begin
      masked_dat[8*i +: 8] = i_wb_sel[i] ? i_wb_dat[8*i +: 8] : 8'h00;
    end
  end

  always_comb
  begin
    status_word = '0;
    status_word[wb_adder_pkg::STAT_IN_RDY]  = i_op_rdy;
    status_word[wb_adder_pkg::STAT_OUT_VAL] = i_sum_val;
    status_word[wb_adder_pkg::STAT_HALF]    = i_half;
  end

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      state_q <= S_IDLE;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          if (req)
          begin
            if (i_wb_we && hit_operand)
              state_q <= S_PUSH;
            else if (!i_wb_we && hit_result)
              state_q <= S_POP;
            else
              state_q <= S_ACK;
          end
        end
        // wait for the adder to take the operand
        S_PUSH:
        begin
          if (i_op_rdy)
            state_q <= S_ACK;
        end
        // wait for a sum
        S_POP:
        begin
          if (i_sum_val)
            state_q <= S_ACK;
        end
        S_ACK:
        begin
          state_q <= S_IDLE;
        end
        default:
        begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // operand and read data registers
  always_ff @(posedge clk)
  begin
    if (req && i_wb_we && hit_operand)
    begin
      op_data_q <= masked_dat;
    end
    if (req)
    begin
      if (!i_wb_we && hit_status)
        rdata_q <= status_word;
      else
        rdata_q <= '0;
    end
    else if (state_q == S_POP && i_sum_val)
    begin
      rdata_q <= i_sum_data;
    end
  end

  assign o_op_val  = (state_q == S_PUSH);
  assign o_op_data = op_data_q;
  assign o_sum_rdy = (state_q == S_POP);
  assign o_wb_ack  = (state_q == S_ACK);
  assign o_wb_dat  = rdata_q;

  // one ack per access and never back to back
  a_ack_single: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wb_ack |=> !o_wb_ack);

  // pushed operand held until the adder takes it
  a_op_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_op_val && !i_op_rdy) |=> (o_op_val && $stable(o_op_data)));

endmodule

`default_nettype wire

/* verilog/wb_adder_pkg.sv */
`default_nettype none

package wb_adder_pkg;

  // data word on the bus and on both streams
  typedef logic [31:0] word_t;

  // wishbone byte address
  typedef logic [31:0] addr_t;

  // one select bit per byte lane
  typedef logic [3:0] sel_t;

  // register map
  // writes to the operand register push one operand and reads return zero
  localparam addr_t ADDR_OPERAND = 32'h3000_0000;
  // reads of the result register pop the sum
  localparam addr_t ADDR_RESULT  = 32'h3000_0004;
  // read-only status register
  localparam addr_t ADDR_STATUS  = 32'h3000_0008;

  // status word bit positions
  // adder accepts an operand
  localparam int STAT_IN_RDY  = 0;
  // a sum is waiting
  localparam int STAT_OUT_VAL = 1;
  // first operand held
  localparam int STAT_HALF    = 2;

endpackage

`default_nettype wire
